// ==== verilog/tag_alloc_config.svh ====
/* Tag allocator configuration
   Tag count, tag number width and lane count, fixed for the 64-bit prefix tree */

`ifndef TAG_ALLOC_CONFIG_SVH
`define TAG_ALLOC_CONFIG_SVH

`define TAG_COUNT        64
`define TAG_INDEX_WIDTH  6
`define ALLOC_LANES      3

// Wide enough to hold the full count of 64
`define FREE_COUNT_WIDTH 7

`endif

// ==== verilog/tag_alloc_pkg.sv ====
/* Tag allocator datapath types
   Tag numbers, tag bitmaps, per-lane grants and the release strobe */

`include "tag_alloc_config.svh"

package tag_alloc_pkg;

    typedef logic [`TAG_INDEX_WIDTH-1:0] tag_t;

    // One bit per tag, free in the pool bitmap or reserved in the mask
    typedef logic [`TAG_COUNT-1:0] tag_mask_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } alloc_grant_t;

    // Element 0 belongs to lane 0
    typedef alloc_grant_t [`ALLOC_LANES-1:0] alloc_grants_t;

    // One-cycle strobe returning a tag to the pool
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_release_t;

endpackage

// ==== verilog/tag_csr_pkg.sv ====
/* Tag allocator register map
   Register addresses, the register request and the status word layout */

`include "tag_alloc_config.svh"

package tag_csr_pkg;

    typedef enum logic [1:0] {
        REG_RESERVE_LO = 2'd0,
        REG_RESERVE_HI = 2'd1,
        REG_STATUS     = 2'd2,
        REG_ID         = 2'd3
    } csr_reg_e;

    typedef struct packed {
        logic        write;
        csr_reg_e    addr;
        logic [31:0] wdata;
    } csr_req_t;

    // Error in bit 8, free count from bit 0
    typedef struct packed {
        logic [22:0]                    unused_hi;
        logic                           release_error;
        logic [7-`FREE_COUNT_WIDTH:0]   unused_lo;
        logic [`FREE_COUNT_WIDTH-1:0]   free_count;
    } csr_status_t;

endpackage

// ==== verilog/triple_priority_encoder.sv ====
/* Triple priority encoder
   Picks the three lowest set bits of a 64-bit vector with parallel-prefix stages
   and compacts the picks onto the enabled lanes */

`timescale 1ns/1ns

`include "tag_alloc_config.svh"

module triple_priority_encoder (
    input  tag_alloc_pkg::tag_mask_t     data_in,
    input  logic                         first_enable,
    input  logic                         second_enable,
    input  logic                         third_enable,
    output tag_alloc_pkg::alloc_grants_t grants
);
    import tag_alloc_pkg::*;

    // Stage s works on the input with the s lowest set bits removed
    tag_mask_t               stage_in     [`ALLOC_LANES];
    tag_mask_t               stage_onehot [`ALLOC_LANES];
    tag_t                    stage_index  [`ALLOC_LANES];
    logic [`ALLOC_LANES-1:0] stage_valid;

    logic [`ALLOC_LANES-1:0] lane_enable;
    logic [1:0]              lane_pick    [`ALLOC_LANES];

    assign stage_in[0] = data_in;

    for (genvar s = 0; s < `ALLOC_LANES; s++) begin : g_stage
        tag_mask_t lower    [`TAG_INDEX_WIDTH+1];
        tag_mask_t half_vec [`TAG_INDEX_WIDTH];
        tag_t      half_sel;

        // Prefix OR of everything below each bit, by doubling shifts
        assign lower[0] = stage_in[s] << 1;
        for (genvar k = 0; k < `TAG_INDEX_WIDTH; k++) begin : g_prefix
            assign lower[k+1] = lower[k] | (lower[k] << (1 << k));
        end

        assign stage_onehot[s] = stage_in[s] & ~lower[`TAG_INDEX_WIDTH];
        assign stage_valid[s]  = |stage_in[s];

        // One-hot to index, halving the window each level
        assign half_vec[0] = stage_onehot[s];
        for (genvar k = 0; k < `TAG_INDEX_WIDTH; k++) begin : g_halve
            localparam int        HALF     = (`TAG_COUNT / 2) >> k;
            localparam tag_mask_t LOW_MASK = (tag_mask_t'(1) << HALF) - tag_mask_t'(1);

            // Bit set when the hot bit sits in the upper half
            assign half_sel[`TAG_INDEX_WIDTH-1-k] = ~|(half_vec[k] & LOW_MASK);

            if (k < `TAG_INDEX_WIDTH - 1) begin : g_next
                assign half_vec[k+1] = half_sel[`TAG_INDEX_WIDTH-1-k]
                                     ? (half_vec[k] >> HALF)
                                     : (half_vec[k] & LOW_MASK);
            end
        end

        assign stage_index[s] = half_sel;

        // Knock out this stage's pick before the next one
        if (s < `ALLOC_LANES - 1) begin : g_chain
            assign stage_in[s+1] = stage_in[s] & ~stage_onehot[s];
        end
    end

    assign lane_enable = {third_enable, second_enable, first_enable};

    // A lane takes the stage matching the number of enabled lanes below it
    assign lane_pick[0] = 2'd0;
    assign lane_pick[1] = {1'b0, first_enable};
    assign lane_pick[2] = {1'b0, first_enable} + {1'b0, second_enable};

    always_comb begin
        for (int l = 0; l < `ALLOC_LANES; l++) begin
            grants[l].valid = lane_enable[l] & stage_valid[lane_pick[l]];
            // Idle or starved lanes read as zero
            grants[l].tag   = grants[l].valid ? stage_index[lane_pick[l]] : '0;
        end
    end

endmodule

// ==== verilog/tag_pool.sv ====
/* Tag pool
   Free bitmap and running free count, updated by grants and releases */

`timescale 1ns/1ns

`include "tag_alloc_config.svh"

module tag_pool (
    input  logic                               clk,
    input  logic                               reset,
    input  tag_alloc_pkg::tag_mask_t           reserve_mask,
    input  tag_alloc_pkg::alloc_grants_t       grants,
    input  tag_alloc_pkg::tag_release_t        release_in,
    output tag_alloc_pkg::tag_mask_t           avail,
    output logic [`FREE_COUNT_WIDTH-1:0]       free_count,
    output logic                               release_conflict
);
    import tag_alloc_pkg::*;

    localparam int CW = `FREE_COUNT_WIDTH;

    tag_mask_t  free_map;
    tag_mask_t  grant_clear;
    tag_mask_t  release_set;
    logic [1:0] grant_total;
    logic       release_ok;

    // Reserved tags stay free but are hidden from the encoder
    assign avail = free_map & ~reserve_mask;

    always_comb begin
        grant_clear = '0;
        grant_total = '0;
        for (int l = 0; l < `ALLOC_LANES; l++) begin
            if (grants[l].valid) begin
                grant_clear[grants[l].tag] = 1'b1;
                grant_total = grant_total + 2'd1;
            end
        end
    end

    // Releasing a tag that is already free is an error, not a change
    assign release_ok       = release_in.valid & ~free_map[release_in.tag];
    assign release_conflict = release_in.valid &  free_map[release_in.tag];

    always_comb begin
        release_set = '0;
        release_set[release_in.tag] = release_ok;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            free_map   <= '1;
            free_count <= CW'(`TAG_COUNT);
        end else begin
            free_map   <= (free_map & ~grant_clear) | release_set;
            free_count <= free_count + CW'(release_ok) - CW'(grant_total);
        end
    end

    // Encoder picks must come from the available set
    for (genvar l = 0; l < `ALLOC_LANES; l++) begin : g_grant_check
        a_grant_available: assert property (
            @(posedge clk) disable iff (reset)
            grants[l].valid |-> avail[grants[l].tag]
        );
    end

    // Distinct tags per cycle, so each grant clears its own bit
    a_grant_unique: assert property (
        @(posedge clk) disable iff (reset)
        $countones(grant_clear) == grant_total
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        free_count <= CW'(`TAG_COUNT)
    );

endmodule

// ==== verilog/tag_alloc_csr.sv ====
/* Tag allocator register block
   Reserve mask, sticky release error and the read multiplexer */

`timescale 1ns/1ns

`include "tag_alloc_config.svh"

module tag_alloc_csr (
    input  logic                          clk,
    input  logic                          reset,
    input  tag_csr_pkg::csr_req_t         csr_in,
    input  logic [`FREE_COUNT_WIDTH-1:0]  free_count,
    input  logic                          release_conflict,
    output tag_alloc_pkg::tag_mask_t      reserve_mask,
    output logic [31:0]                   csr_rdata
);
    import tag_csr_pkg::*;

    logic        write_lo;
    logic        write_hi;
    logic        write_status;
    logic        release_error;
    csr_status_t status_word;

    assign write_lo     = csr_in.write && (csr_in.addr == REG_RESERVE_LO);
    assign write_hi     = csr_in.write && (csr_in.addr == REG_RESERVE_HI);
    // Status is read only, a write there just clears the error
    assign write_status = csr_in.write && (csr_in.addr == REG_STATUS);

    always_ff @(posedge clk) begin
        if (reset) begin
            reserve_mask <= '0;
        end else begin
            if (write_lo) begin
                reserve_mask[31:0] <= csr_in.wdata;
            end
            if (write_hi) begin
                reserve_mask[63:32] <= csr_in.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            release_error <= 1'b0;
        end else if (release_conflict) begin
            // New error wins over a clear in the same cycle
            release_error <= 1'b1;
        end else if (write_status) begin
            release_error <= 1'b0;
        end
    end

    always_comb begin
        status_word               = '0;
        status_word.release_error = release_error;
        status_word.free_count    = free_count;
    end

    always_comb begin
        case (csr_in.addr)
            REG_RESERVE_LO: csr_rdata = reserve_mask[31:0];
            REG_RESERVE_HI: csr_rdata = reserve_mask[63:32];
            REG_STATUS:     csr_rdata = status_word;
            REG_ID:         csr_rdata = 32'(`TAG_COUNT);
            default:        csr_rdata = '0;
        endcase
    end

    // ID register has no write side
    a_no_id_write: assert property (
        @(posedge clk) disable iff (reset)
        csr_in.write |-> (csr_in.addr != REG_ID)
    );

endmodule

// ==== verilog/tag_alloc_top.sv ====
/* Tag allocator top level
   Hands out up to three free tags per clock, lowest numbers first */

`timescale 1ns/1ns

`include "tag_alloc_config.svh"

module tag_alloc_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`ALLOC_LANES-1:0]       alloc_req,
    input  tag_alloc_pkg::tag_release_t   release_in,
    input  tag_csr_pkg::csr_req_t         csr_in,
    output tag_alloc_pkg::alloc_grants_t  grants,
    output logic [31:0]                   csr_rdata
);
    import tag_alloc_pkg::*;

    tag_mask_t                    avail;
    tag_mask_t                    reserve_mask;
    logic [`FREE_COUNT_WIDTH-1:0] free_count;
    logic                         release_conflict;

    tag_pool i_tag_pool (
        .clk              (clk),
        .reset            (reset),
        .reserve_mask     (reserve_mask),
        .grants           (grants),
        .release_in       (release_in),
        .avail            (avail),
        .free_count       (free_count),
        .release_conflict (release_conflict)
    );

    tag_alloc_csr i_tag_alloc_csr (
        .clk              (clk),
        .reset            (reset),
        .csr_in           (csr_in),
        .free_count       (free_count),
        .release_conflict (release_conflict),
        .reserve_mask     (reserve_mask),
        .csr_rdata        (csr_rdata)
    );

    // Each request bit enables one lane
    triple_priority_encoder i_triple_priority_encoder (
        .data_in       (avail),
        .first_enable  (alloc_req[0]),
        .second_enable (alloc_req[1]),
        .third_enable  (alloc_req[2]),
        .grants        (grants)
    );

endmodule

// ==== tb/tag_alloc_tb.sv ====
/* Tag allocator testbench
   LFSR-driven allocation, release and register traffic checked against a reference model */

`timescale 1ns/1ns

`include "tag_alloc_config.svh"

module tag_alloc_tb;
    import tag_alloc_pkg::*;
    import tag_csr_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                    clk;
    logic                    reset;
    logic [`ALLOC_LANES-1:0] alloc_req;
    tag_release_t            release_in;
    csr_req_t                csr_in;
    alloc_grants_t           grants;
    logic [31:0]             csr_rdata;

    // Reference model state
    tag_mask_t   model_free;
    tag_mask_t   model_reserve;
    int          model_count;
    logic        model_error;
    logic [15:0] lfsr_state;

    tag_alloc_top i_tag_alloc_top (
        .clk        (clk),
        .reset      (reset),
        .alloc_req  (alloc_req),
        .release_in (release_in),
        .csr_in     (csr_in),
        .grants     (grants),
        .csr_rdata  (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns: %s did not happen within %0d cycles",
                 $time, what, WAIT_LIMIT);
        $display("Done: errors found");
        $fatal(1, "Wait limit exceeded");
    endtask

    function automatic tag_release_t no_release();
        return '0;
    endfunction

    function automatic tag_release_t make_release(tag_t tag);
        tag_release_t r;
        r.valid = 1'b1;
        r.tag   = tag;
        return r;
    endfunction

    function automatic csr_req_t csr_read(csr_reg_e addr);
        csr_req_t r;
        r      = '0;
        r.addr = addr;
        return r;
    endfunction

    function automatic csr_req_t csr_write(csr_reg_e addr, logic [31:0] data);
        csr_req_t r;
        r.write = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    // Lowest available tags go to the requesting lanes in lane order
    function automatic alloc_grants_t predict_grants(logic [2:0] req);
        alloc_grants_t g;
        tag_mask_t     pool;
        logic          found;
        g    = '0;
        pool = model_free & ~model_reserve;
        for (int l = 0; l < `ALLOC_LANES; l++) begin
            found = 1'b0;
            for (int t = 0; t < `TAG_COUNT; t++) begin
                if (req[l] && !found && pool[t]) begin
                    found      = 1'b1;
                    g[l].valid = 1'b1;
                    g[l].tag   = tag_t'(t);
                    pool[t]    = 1'b0;
                end
            end
        end
        return g;
    endfunction

    function automatic logic [31:0] expected_read(csr_reg_e addr);
        case (addr)
            REG_RESERVE_LO: return model_reserve[31:0];
            REG_RESERVE_HI: return model_reserve[63:32];
            REG_STATUS:     return {23'd0, model_error, 1'b0, 7'(model_count)};
            default:        return 32'd64;
        endcase
    endfunction

    task automatic update_model(input alloc_grants_t g, input tag_release_t rel,
                                input csr_req_t csr);
        logic conflict;
        conflict = rel.valid && model_free[rel.tag];
        for (int l = 0; l < `ALLOC_LANES; l++) begin
            if (g[l].valid) begin
                model_free[g[l].tag] = 1'b0;
                model_count--;
            end
        end
        if (rel.valid && !conflict) begin
            model_free[rel.tag] = 1'b1;
            model_count++;
        end
        if (csr.write && csr.addr == REG_RESERVE_LO) model_reserve[31:0] = csr.wdata;
        if (csr.write && csr.addr == REG_RESERVE_HI) model_reserve[63:32] = csr.wdata;
        if (conflict) begin
            model_error = 1'b1;
        end else if (csr.write && csr.addr == REG_STATUS) begin
            model_error = 1'b0;
        end
    endtask

    // Drive on the rising edge, check at the falling edge, then step the model
    task automatic run_cycle(input logic [2:0] req, input tag_release_t rel,
                             input csr_req_t csr);
        alloc_grants_t exp_grants;
        @(posedge clk);
        alloc_req  <= req;
        release_in <= rel;
        csr_in     <= csr;
        @(negedge clk);
        exp_grants = predict_grants(req);
        for (int l = 0; l < `ALLOC_LANES; l++) begin
            check_value($sformatf("grants[%0d].valid", l), exp_grants[l].valid, grants[l].valid);
            check_value($sformatf("grants[%0d].tag", l), exp_grants[l].tag, grants[l].tag);
        end
        check_value("csr_rdata", expected_read(csr.addr), csr_rdata);
        update_model(exp_grants, rel, csr);
    endtask

    task automatic pick_allocated(output logic found, output tag_t tag);
        logic [63:0] start;
        int          t;
        found = 1'b0;
        tag   = '0;
        random_bits(6, start);
        for (int i = 0; i < `TAG_COUNT; i++) begin
            t = (int'(start[5:0]) + i) % `TAG_COUNT;
            if (!found && !model_free[t]) begin
                found = 1'b1;
                tag   = tag_t'(t);
            end
        end
    endtask

    task automatic drain_available(input string what);
        logic [63:0] bits;
        int          cycles;
        cycles = 0;
        while ((model_free & ~model_reserve) != '0) begin
            if (cycles >= WAIT_LIMIT) timeout_fail(what);
            random_bits(3, bits);
            run_cycle(bits[2:0], no_release(), csr_read(REG_STATUS));
            cycles++;
        end
    endtask

    task automatic read_status(input int exp_count, input logic exp_error);
        run_cycle(3'b000, no_release(), csr_read(REG_STATUS));
        check_value("status free_count", exp_count, csr_rdata[6:0]);
        check_value("status release_error", exp_error, csr_rdata[8]);
    endtask

    initial begin
        logic [63:0] bits;
        logic [63:0] mask;
        logic        found;
        tag_t        tag;

        reset         = 1'b1;
        alloc_req     = '0;
        release_in    = '0;
        csr_in        = '0;
        lfsr_state    = 16'd63;
        model_free    = '1;
        model_reserve = '0;
        model_count   = `TAG_COUNT;
        model_error   = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // After reset
        read_status(`TAG_COUNT, 1'b0);
        run_cycle(3'b000, no_release(), csr_read(REG_ID));
        check_value("REG_ID", `TAG_COUNT, csr_rdata);

        // Random allocation until the pool drains
        run_cycle(3'b101, no_release(), csr_read(REG_STATUS));
        run_cycle(3'b010, no_release(), csr_read(REG_STATUS));
        drain_available("pool drain");
        repeat (3) run_cycle(3'b111, no_release(), csr_read(REG_STATUS));
        check_value("grant valids when empty", 3'b000,
                    {grants[2].valid, grants[1].valid, grants[0].valid});
        read_status(0, 1'b0);

        // Releases mixed with allocation
        for (int i = 0; i < 300; i++) begin
            random_bits(6, bits);
            found = 1'b0;
            tag   = '0;
            if (bits[3]) pick_allocated(found, tag);
            run_cycle(bits[2:0], found ? make_release(tag) : no_release(),
                      csr_read(csr_reg_e'(bits[5:4])));
        end
        read_status(model_count, 1'b0);

        // Reserve mask, starting from a full pool
        for (int t = 0; t < `TAG_COUNT; t++) begin
            if (!model_free[t]) run_cycle(3'b000, make_release(tag_t'(t)), csr_read(REG_STATUS));
        end
        read_status(`TAG_COUNT, 1'b0);
        random_bits(64, mask);
        run_cycle(3'b000, no_release(), csr_write(REG_RESERVE_LO, mask[31:0]));
        run_cycle(3'b000, no_release(), csr_write(REG_RESERVE_HI, mask[63:32]));
        run_cycle(3'b000, no_release(), csr_read(REG_RESERVE_LO));
        check_value("reserve lo readback", mask[31:0], csr_rdata);
        run_cycle(3'b000, no_release(), csr_read(REG_RESERVE_HI));
        check_value("reserve hi readback", mask[63:32], csr_rdata);
        drain_available("drain of unreserved tags");
        // Only the reserved tags are left, still counted as free
        read_status($countones(mask), 1'b0);
        run_cycle(3'b000, no_release(), csr_write(REG_RESERVE_LO, 32'd0));
        run_cycle(3'b000, no_release(), csr_write(REG_RESERVE_HI, 32'd0));
        drain_available("drain of formerly reserved tags");
        read_status(0, 1'b0);

        // Release error on a tag that is already free
        run_cycle(3'b000, make_release(tag_t'(17)), csr_read(REG_STATUS));
        read_status(1, 1'b0);
        run_cycle(3'b000, make_release(tag_t'(17)), csr_read(REG_STATUS));
        read_status(1, 1'b1);
        run_cycle(3'b000, make_release(tag_t'(3)), csr_read(REG_STATUS));
        run_cycle(3'b000, make_release(tag_t'(40)), csr_read(REG_STATUS));
        read_status(3, 1'b1);
        run_cycle(3'b000, no_release(), csr_write(REG_STATUS, 32'd0));
        read_status(3, 1'b0);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== tag_alloc.f ====
+incdir+verilog
verilog/tag_alloc_pkg.sv
verilog/tag_csr_pkg.sv
verilog/triple_priority_encoder.sv
verilog/tag_pool.sv
verilog/tag_alloc_csr.sv
verilog/tag_alloc_top.sv
tb/tag_alloc_tb.sv
